// ==== source/pe_array_pkg.sv ====
/*
  MAC array geometry, parameter register field positions and the array-side types.
  Import this package into any block that decodes acc_params or drives the mux controls.
*/
`default_nettype none

package pe_array_pkg;

  // array geometry
  localparam int PE_ROWS = 5;
  localparam int PE_COLS = 5;

  // valid cycles needed to fill the MAC pipeline
  localparam int MAC_PIPE_DEPTH = 2;

  // acc_params field positions
  localparam int PARAM_R_LSB    = 0;
  localparam int PARAM_S_LSB    = 4;
  localparam int PARAM_TILE_LSB = 12;

  // acc_params control bits
  localparam int PARAM_RESET_BIT = 29;
  localparam int PARAM_START_BIT = 30;
  localparam int PARAM_VALID_BIT = 31;

  // filter height, filter width or tile size
  typedef logic [3:0] dim_t;

  // add enables for one row, column 0 first
  typedef logic [0:PE_COLS-1] add_mux_row_t;

  typedef logic [3:0] row_mux_t;
  typedef logic [2:0] psum_mux_t;

  // cycle count within one run, holds up to 15 x 15
  typedef logic [7:0] run_count_t;

endpackage

`default_nettype wire

// ==== source/pe_mem_pkg.sv ====
/*
  Bus word and address types, burst sizing and the memory control and status bit map.
  Shared by the fetch path, the status register and the top level.
*/
`default_nettype none

package pe_mem_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // burst shape on the memory master
  localparam int BURST_LEN     = 16;
  localparam int BURST_BYTES   = BURST_LEN * $bits(word_t) / 8;
  localparam int WEIGHT_BURSTS = 1;
  localparam int INPUT_BURSTS  = 2;

  // mem_ctrl request bits
  localparam int MEMCTL_BUF_WEIGHTS = 0;
  localparam int MEMCTL_BUF_INPUTS  = 3;

  // pe_status bit map, flags low and errors in the upper half
  localparam int STAT_WEIGHTS_OK = 0;
  localparam int STAT_INPUTS_OK  = 1;
  localparam int STAT_COMPUTED   = 2;
  localparam int STAT_WEIGHT_ERR = 16;
  localparam int STAT_INPUT_ERR  = 17;

  // read address while no burst is pending
  localparam addr_t IDLE_ADDR = 32'h40000000;

endpackage

`default_nettype wire

// ==== source/fetch_sequencer.sv ====
/*
  Turns weight and input buffer requests from mem_ctrl into read bursts on the memory
  master handshake, and strobes the returned beats into the external buffers.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer import pe_mem_pkg::*; (
  input  wire         CLK,
  input  wire         RESETN,
  input  wire word_t  mem_ctrl,
  input  wire addr_t  weight_base_addr,
  input  wire addr_t  input_base_addr,
  input  wire word_t  rd_data,
  input  wire         rd_beat,
  input  wire         txn_done,
  input  wire         axi_error,
  output logic        init_rd_txn,
  output addr_t       rd_addr,
  output logic        weight_buf_wr,
  output logic        act_buf_wr,
  output word_t       buf_wr_data,
  output logic        weights_buffered,
  output logic        inputs_buffered,
  output logic        weight_err,
  output logic        input_err
);

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_ISSUE,
    FETCH_WAIT,
    FETCH_ACCOUNT
  } fetch_state_t;

  fetch_state_t state;
  logic         weight_req_q;
  logic         input_req_q;
  logic         weight_rise;
  logic         input_rise;
  logic         weight_pend;
  logic         input_pend;
  logic         cur_input;
  logic [1:0]   burst_cnt;
  addr_t        addr_off;
  logic         last_burst;
  logic         mid_request;
  logic         have_work;
  logic         pick_input;
  logic         busy;

  assign weight_rise = mem_ctrl[MEMCTL_BUF_WEIGHTS] & ~weight_req_q;
  assign input_rise  = mem_ctrl[MEMCTL_BUF_INPUTS] & ~input_req_q;

  assign last_burst = cur_input ? (burst_cnt == 2'(INPUT_BURSTS - 1))
                                : (burst_cnt == 2'(WEIGHT_BURSTS - 1));

  // a request with bursts left keeps the master, otherwise weights win
  assign mid_request = (burst_cnt != '0);
  assign have_work   = mid_request || weight_pend || input_pend;
  assign pick_input  = mid_request ? cur_input : ~weight_pend;

  // beats only belong to us between issue and txn_done
  assign busy          = (state == FETCH_ISSUE) || (state == FETCH_WAIT);
  assign weight_buf_wr = rd_beat & busy & ~cur_input;
  assign act_buf_wr    = rd_beat & busy & cur_input;
  assign buf_wr_data   = rd_data;

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state            <= FETCH_IDLE;
      weight_req_q     <= 1'b0;
      input_req_q      <= 1'b0;
      weight_pend      <= 1'b0;
      input_pend       <= 1'b0;
      cur_input        <= 1'b0;
      burst_cnt        <= '0;
      addr_off         <= '0;
      init_rd_txn      <= 1'b0;
      rd_addr          <= IDLE_ADDR;
      weights_buffered <= 1'b0;
      inputs_buffered  <= 1'b0;
      weight_err       <= 1'b0;
      input_err        <= 1'b0;
    end else begin
      weight_req_q <= mem_ctrl[MEMCTL_BUF_WEIGHTS];
      input_req_q  <= mem_ctrl[MEMCTL_BUF_INPUTS];
      init_rd_txn  <= 1'b0;

      case (state)
        FETCH_IDLE: begin
          if (weight_pend || input_pend) begin
            state <= FETCH_ACCOUNT;
          end
        end
        FETCH_ACCOUNT: begin
          if (have_work) begin
            cur_input   <= pick_input;
            rd_addr     <= (pick_input ? input_base_addr : weight_base_addr) + addr_off;
            init_rd_txn <= 1'b1;
            state       <= FETCH_ISSUE;
            // request leaves the queue once its first burst goes out
            if (!mid_request) begin
              if (pick_input) begin
                input_pend <= 1'b0;
              end else begin
                weight_pend <= 1'b0;
              end
            end
          end else begin
            rd_addr <= IDLE_ADDR;
            state   <= FETCH_IDLE;
          end
        end
        FETCH_ISSUE: begin
          state <= FETCH_WAIT;
        end
        FETCH_WAIT: begin
          if (txn_done) begin
            state <= FETCH_ACCOUNT;
            if (last_burst) begin
              burst_cnt <= '0;
              addr_off  <= '0;
            end else begin
              burst_cnt <= burst_cnt + 2'd1;
              addr_off  <= addr_off + addr_t'(BURST_BYTES);
            end
            if (cur_input) begin
              input_err <= input_err | axi_error;
              if (last_burst) begin
                inputs_buffered <= 1'b1;
              end
            end else begin
              weight_err <= weight_err | axi_error;
              if (last_burst) begin
                weights_buffered <= 1'b1;
              end
            end
          end
        end
        default: begin
          state <= FETCH_IDLE;
        end
      endcase

      // new requests, placed last so they win over the clears above
      if (weight_rise) begin
        weight_pend      <= 1'b1;
        weights_buffered <= 1'b0;
        weight_err       <= 1'b0;
      end
      if (input_rise) begin
        input_pend      <= 1'b1;
        inputs_buffered <= 1'b0;
        input_err       <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/mac_sequencer.sv ====
/*
  Decodes acc_params into the MAC array mux controls and sequences one array run:
  priming, counted compute, stall on missing activations, then the output drain strobes.
*/
`timescale 1ns/1ps
`default_nettype none

module mac_sequencer import pe_array_pkg::*, pe_mem_pkg::*; (
  input  wire          CLK,
  input  wire          RESETN,
  input  wire word_t   acc_params,
  input  wire          act_valid,
  output logic         mac_resetn,
  output logic         stall,
  output logic         out_wr,
  output logic         computed,
  output add_mux_row_t add_mux_ctrl [PE_ROWS],
  output row_mux_t     row_out_mux_ctrl [PE_ROWS],
  output psum_mux_t    psum_out_mux_ctrl
);

  typedef enum logic [1:0] {
    MAC_IDLE,
    MAC_PRIME,
    MAC_COMPUTE,
    MAC_DRAIN
  } mac_state_t;

  dim_t       param_r;
  dim_t       param_s;
  dim_t       param_tile;
  logic       param_reset;
  logic       param_start;
  logic       param_valid;
  logic       resetn_all;
  logic       start_q;
  logic       start_rise;
  mac_state_t state;
  run_count_t run_cnt;
  run_count_t run_len;

  assign param_r     = acc_params[PARAM_R_LSB +: $bits(dim_t)];
  assign param_s     = acc_params[PARAM_S_LSB +: $bits(dim_t)];
  assign param_tile  = acc_params[PARAM_TILE_LSB +: $bits(dim_t)];
  assign param_reset = acc_params[PARAM_RESET_BIT];
  assign param_start = acc_params[PARAM_START_BIT];
  assign param_valid = acc_params[PARAM_VALID_BIT];

  // soft reset takes down the compute side and the array together
  assign resetn_all = RESETN & ~param_reset;
  assign mac_resetn = resetn_all;
  assign start_rise = param_start & ~start_q;

  // stall whenever the array is not fed, never while draining
  assign stall  = (state == MAC_IDLE) ||
                  (((state == MAC_PRIME) || (state == MAC_COMPUTE)) && !act_valid);
  assign out_wr = (state == MAC_DRAIN);

  // compute and drain length, fixed for the whole run
  always_ff @(posedge CLK) begin
    if (state == MAC_IDLE && start_rise) begin
      run_len <= run_count_t'(param_tile) * run_count_t'(param_r);
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn_all) begin
      for (int r = 0; r < PE_ROWS; r++) begin
        add_mux_ctrl[r]     <= '0;
        row_out_mux_ctrl[r] <= '0;
      end
      psum_out_mux_ctrl <= '0;
    end else if (param_valid) begin
      for (int r = 0; r < PE_ROWS; r++) begin
        // first S columns of the first R rows accumulate
        for (int c = 0; c < PE_COLS; c++) begin
          add_mux_ctrl[r][c] <= (r < int'(param_r)) && (c < int'(param_s));
        end
        row_out_mux_ctrl[r] <= row_mux_t'(param_tile - dim_t'(1));
      end
      psum_out_mux_ctrl <= psum_mux_t'(param_r - dim_t'(1));
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn_all) begin
      state    <= MAC_IDLE;
      run_cnt  <= '0;
      start_q  <= 1'b0;
      computed <= 1'b0;
    end else begin
      start_q <= param_start;
      case (state)
        MAC_IDLE: begin
          if (start_rise) begin
            run_cnt  <= '0;
            computed <= 1'b0;
            state    <= MAC_PRIME;
          end
        end
        MAC_PRIME: begin
          if (act_valid) begin
            if (run_cnt == run_count_t'(MAC_PIPE_DEPTH - 1)) begin
              run_cnt <= '0;
              // empty tile has nothing to compute or drain
              if (run_len == '0) begin
                computed <= 1'b1;
                state    <= MAC_IDLE;
              end else begin
                state <= MAC_COMPUTE;
              end
            end else begin
              run_cnt <= run_cnt + run_count_t'(1);
            end
          end
        end
        MAC_COMPUTE: begin
          if (act_valid) begin
            if (run_cnt == run_len - run_count_t'(1)) begin
              run_cnt <= '0;
              state   <= MAC_DRAIN;
            end else begin
              run_cnt <= run_cnt + run_count_t'(1);
            end
          end
        end
        MAC_DRAIN: begin
          if (run_cnt == run_len - run_count_t'(1)) begin
            run_cnt  <= '0;
            computed <= 1'b1;
            state    <= MAC_IDLE;
          end else begin
            run_cnt <= run_cnt + run_count_t'(1);
          end
        end
        default: begin
          state <= MAC_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/pe_status_reg.sv ====
/*
  Registers the fetch and compute flags into the pe_status word read by the host.
*/
`timescale 1ns/1ps
`default_nettype none

module pe_status_reg import pe_mem_pkg::*; (
  input  wire   CLK,
  input  wire   RESETN,
  input  wire   weights_buffered,
  input  wire   inputs_buffered,
  input  wire   computed,
  input  wire   weight_err,
  input  wire   input_err,
  output word_t pe_status
);

  word_t status_next;

  // unused bits read back as zero
  always_comb begin
    status_next                  = '0;
    status_next[STAT_WEIGHTS_OK] = weights_buffered;
    status_next[STAT_INPUTS_OK]  = inputs_buffered;
    status_next[STAT_COMPUTED]   = computed;
    status_next[STAT_WEIGHT_ERR] = weight_err;
    status_next[STAT_INPUT_ERR]  = input_err;
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      pe_status <= '0;
    end else begin
      pe_status <= status_next;
    end
  end

endmodule

`default_nettype wire

// ==== source/pe_control_unit.sv ====
/*
  PE control unit top level. Connects the fetch path, the compute path and the status
  register to the host registers, the memory master and the MAC array.
*/
`timescale 1ns/1ps
`default_nettype none

module pe_control_unit import pe_array_pkg::*, pe_mem_pkg::*; (
  input  wire               CLK,
  input  wire               RESETN,
  // host registers
  input  wire word_t        acc_params,
  input  wire word_t        mem_ctrl,
  input  wire addr_t        weight_base_addr,
  input  wire addr_t        input_base_addr,
  output wire word_t        pe_status,
  // memory master
  output wire               init_rd_txn,
  output wire addr_t        rd_addr,
  input  wire word_t        rd_data,
  input  wire               rd_beat,
  input  wire               txn_done,
  input  wire               axi_error,
  // external weight and activation buffers
  output wire               weight_buf_wr,
  output wire               act_buf_wr,
  output wire word_t        buf_wr_data,
  // MAC array
  input  wire               act_valid,
  output wire               mac_resetn,
  output wire               stall,
  output wire               out_wr,
  output wire add_mux_row_t add_mux_ctrl [PE_ROWS],
  output wire row_mux_t     row_out_mux_ctrl [PE_ROWS],
  output wire psum_mux_t    psum_out_mux_ctrl
);

  wire weights_buffered;
  wire inputs_buffered;
  wire weight_err;
  wire input_err;
  wire computed;

  fetch_sequencer u_fetch (
    .CLK              (CLK),
    .RESETN           (RESETN),
    .mem_ctrl         (mem_ctrl),
    .weight_base_addr (weight_base_addr),
    .input_base_addr  (input_base_addr),
    .rd_data          (rd_data),
    .rd_beat          (rd_beat),
    .txn_done         (txn_done),
    .axi_error        (axi_error),
    .init_rd_txn      (init_rd_txn),
    .rd_addr          (rd_addr),
    .weight_buf_wr    (weight_buf_wr),
    .act_buf_wr       (act_buf_wr),
    .buf_wr_data      (buf_wr_data),
    .weights_buffered (weights_buffered),
    .inputs_buffered  (inputs_buffered),
    .weight_err       (weight_err),
    .input_err        (input_err)
  );

  mac_sequencer u_mac (
    .CLK               (CLK),
    .RESETN            (RESETN),
    .acc_params        (acc_params),
    .act_valid         (act_valid),
    .mac_resetn        (mac_resetn),
    .stall             (stall),
    .out_wr            (out_wr),
    .computed          (computed),
    .add_mux_ctrl      (add_mux_ctrl),
    .row_out_mux_ctrl  (row_out_mux_ctrl),
    .psum_out_mux_ctrl (psum_out_mux_ctrl)
  );

  pe_status_reg u_status (
    .CLK              (CLK),
    .RESETN           (RESETN),
    .weights_buffered (weights_buffered),
    .inputs_buffered  (inputs_buffered),
    .computed         (computed),
    .weight_err       (weight_err),
    .input_err        (input_err),
    .pe_status        (pe_status)
  );

endmodule

`default_nettype wire

// ==== verif/pe_control_unit_props.sv ====
/*
  Handshake and strobe assertions for the PE control unit, bound into the top level.
*/
`timescale 1ns/1ps
`default_nettype none

module pe_control_unit_props (
  input wire CLK,
  input wire RESETN,
  input wire init_rd_txn,
  input wire txn_done,
  input wire rd_beat,
  input wire weight_buf_wr,
  input wire act_buf_wr,
  input wire out_wr,
  input wire stall
);

  // high from the cycle after init_rd_txn until the cycle after txn_done
  logic txn_open;

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      txn_open <= 1'b0;
    end else if (init_rd_txn) begin
      txn_open <= 1'b1;
    end else if (txn_done) begin
      txn_open <= 1'b0;
    end
  end

  init_single_pulse: assert property (@(posedge CLK) disable iff (!RESETN)
    init_rd_txn |=> !init_rd_txn)
    else $error("init_rd_txn held for more than one cycle");

  no_init_in_flight: assert property (@(posedge CLK) disable iff (!RESETN)
    txn_open |-> !init_rd_txn)
    else $error("init_rd_txn raised before txn_done of the previous burst");

  drain_without_stall: assert property (@(posedge CLK) disable iff (!RESETN)
    !(out_wr && stall))
    else $error("out_wr and stall high together");

  strobe_needs_beat: assert property (@(posedge CLK) disable iff (!RESETN)
    (weight_buf_wr || act_buf_wr) |-> rd_beat)
    else $error("buffer strobe without rd_beat");

endmodule

`default_nettype wire

// ==== verif/tb_pe_control_unit.sv ====
/*
  Testbench for the PE control unit with a memory master model, fetch and MAC run
  stimulus, reference functions and a compare process. Run through the Makefile sim target.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_pe_control_unit import pe_array_pkg::*, pe_mem_pkg::*;;

  localparam int CLK_PERIOD = 8;
  localparam logic [31:0] LCG_SEED = 32'hf6850ea4;

  // per-test budgets in cycles
  localparam int T_RESET  = 20;
  localparam int T_WEIGHT = 100;
  localparam int T_INPUT  = 200;
  localparam int T_MUX    = 10;
  localparam int T_RUN    = 150;
  localparam int T_SOFT   = 10;
  localparam int WATCHDOG_NS =
    (T_RESET + T_WEIGHT + T_INPUT + T_MUX + T_RUN + T_SOFT) * 4 * CLK_PERIOD;

  logic         CLK = 1'b0;
  logic         RESETN;
  word_t        acc_params;
  word_t        mem_ctrl;
  addr_t        weight_base_addr;
  addr_t        input_base_addr;
  word_t        pe_status;
  logic         init_rd_txn;
  addr_t        rd_addr;
  word_t        rd_data;
  logic         rd_beat;
  logic         txn_done;
  logic         axi_error;
  logic         weight_buf_wr;
  logic         act_buf_wr;
  word_t        buf_wr_data;
  logic         act_valid;
  logic         mac_resetn;
  logic         stall;
  logic         out_wr;
  add_mux_row_t add_mux_ctrl [PE_ROWS];
  row_mux_t     row_out_mux_ctrl [PE_ROWS];
  psum_mux_t    psum_out_mux_ctrl;

  // results and bookkeeping
  int    checks = 0;
  int    errors = 0;
  int    test_errors = 0;
  int    test_no = 0;
  int    bursts_served = 0;
  int    error_burst = -1;
  addr_t burst_addrs [$];
  int    weight_strobes;
  int    act_strobes;
  logic  run_watch = 1'b0;
  int    valid_seen;
  int    out_wr_cnt;
  int    first_out_valid;
  int    first_out_cycle;
  int    last_out_cycle;
  int    computed_cycle;

  pe_control_unit DUT (.*);

  bind pe_control_unit pe_control_unit_props u_props (
    .CLK           (CLK),
    .RESETN        (RESETN),
    .init_rd_txn   (init_rd_txn),
    .txn_done      (txn_done),
    .rd_beat       (rd_beat),
    .weight_buf_wr (weight_buf_wr),
    .act_buf_wr    (act_buf_wr),
    .out_wr        (out_wr),
    .stall         (stall)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // beat payload unique per address and beat
  function automatic word_t beat_data(input addr_t addr, input int beat);
    return (addr + addr_t'(4 * beat)) ^ 32'h9e3779b9;
  endfunction

  function automatic word_t make_params(input dim_t r, input dim_t s, input dim_t tile,
                                        input logic soft_reset, input logic start,
                                        input logic valid);
    word_t w;
    w = '0;
    w[PARAM_R_LSB +: $bits(dim_t)]    = r;
    w[PARAM_S_LSB +: $bits(dim_t)]    = s;
    w[PARAM_TILE_LSB +: $bits(dim_t)] = tile;
    w[PARAM_RESET_BIT] = soft_reset;
    w[PARAM_START_BIT] = start;
    w[PARAM_VALID_BIT] = valid;
    return w;
  endfunction

  // reference model
  function automatic word_t expected_status(input logic w_ok, input logic i_ok,
                                            input logic comp, input logic w_err,
                                            input logic i_err);
    word_t s;
    s = '0;
    s[STAT_WEIGHTS_OK] = w_ok;
    s[STAT_INPUTS_OK]  = i_ok;
    s[STAT_COMPUTED]   = comp;
    s[STAT_WEIGHT_ERR] = w_err;
    s[STAT_INPUT_ERR]  = i_err;
    return s;
  endfunction

  function automatic addr_t expected_burst_addr(input addr_t base, input int k);
    return base + addr_t'(k * BURST_BYTES);
  endfunction

  function automatic add_mux_row_t expected_add_row(input int row, input dim_t r,
                                                    input dim_t s);
    add_mux_row_t v;
    for (int c = 0; c < PE_COLS; c++) begin
      v[c] = (row < int'(r)) && (c < int'(s));
    end
    return v;
  endfunction

  function automatic run_count_t expected_run_len(input dim_t tile, input dim_t r);
    int cycles;
    cycles = int'(tile) * int'(r);
    return run_count_t'(cycles);
  endfunction

  task automatic tally_check(input bit ok, input string name, input string got_s,
                             input string exp_s);
    checks++;
    if (!ok) begin
      errors++;
      test_errors++;
      $display("[FAIL] t=%0t %s got %s expected %s", $time, name, got_s, exp_s);
    end
  endtask

  task automatic report_problem(input string msg);
    errors++;
    test_errors++;
    $display("error at t=%0t: %s", $time, msg);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    tally_check(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    tally_check(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic check_dim(input string name, input dim_t got, input dim_t exp);
    tally_check(got === exp, name, $sformatf("%0d", got), $sformatf("%0d", exp));
  endtask

  task automatic check_row(input string name, input add_mux_row_t got,
                           input add_mux_row_t exp);
    tally_check(got === exp, name, $sformatf("%b", got), $sformatf("%b", exp));
  endtask

  task automatic check_count(input string name, input run_count_t got,
                             input run_count_t exp);
    tally_check(got === exp, name, $sformatf("%0d", got), $sformatf("%0d", exp));
  endtask

  task automatic finish_test(input string name);
    test_no++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", test_no, name);
    end else begin
      $display("test %0d %s: %0d errors", test_no, name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic wait_status(input int bit_no, input int limit, input string what);
    int n;
    n = 0;
    while (pe_status[bit_no] !== 1'b1 && n < limit) begin
      @(posedge CLK);
      #1;
      n++;
    end
    if (pe_status[bit_no] !== 1'b1) begin
      report_problem($sformatf("%s did not finish within %0d cycles", what, limit));
    end
  endtask

  task automatic check_mux(input dim_t r, input dim_t s, input dim_t tile);
    for (int row = 0; row < PE_ROWS; row++) begin
      check_row($sformatf("add_mux_ctrl[%0d]", row), add_mux_ctrl[row],
                expected_add_row(row, r, s));
      check_dim($sformatf("row_out_mux_ctrl[%0d]", row), dim_t'(row_out_mux_ctrl[row]),
                tile - dim_t'(1));
    end
    check_dim("psum_out_mux_ctrl", dim_t'(psum_out_mux_ctrl), r - dim_t'(1));
  endtask

  task automatic check_bursts(input addr_t base, input int count, input string name);
    check_word({name, " burst count"}, word_t'(burst_addrs.size()), word_t'(count));
    for (int k = 0; k < count && k < burst_addrs.size(); k++) begin
      check_addr($sformatf("rd_addr burst %0d", k), burst_addrs[k],
                 expected_burst_addr(base, k));
    end
  endtask

  task automatic clear_fetch_stats();
    burst_addrs.delete();
    weight_strobes = 0;
    act_strobes = 0;
  endtask

  // memory master model
  initial begin : memory_master
    logic [31:0] rng;
    addr_t       addr;
    int          gap;
    int          beat;
    rng = LCG_SEED;
    rd_data = '0;
    rd_beat = 1'b0;
    txn_done = 1'b0;
    axi_error = 1'b0;
    forever begin
      @(negedge CLK);
      if (init_rd_txn) begin
        addr = rd_addr;
        rng = lcg_step(rng);
        gap = int'(rng[17:16]) + 1;
        repeat (gap) @(posedge CLK);
        beat = 0;
        while (beat < BURST_LEN) begin
          @(posedge CLK);
          #1;
          rng = lcg_step(rng);
          // roughly one idle cycle in four
          if (rng[20:19] == 2'b00) begin
            rd_beat = 1'b0;
          end else begin
            rd_beat = 1'b1;
            rd_data = beat_data(addr, beat);
            beat++;
          end
        end
        @(posedge CLK);
        #1;
        rd_beat = 1'b0;
        txn_done = 1'b1;
        axi_error = (bursts_served == error_burst);
        @(posedge CLK);
        #1;
        txn_done = 1'b0;
        axi_error = 1'b0;
        bursts_served++;
      end
    end
  end

  // compare process sampling mid-cycle
  initial begin : compare
    int    cycle_no;
    addr_t cur_addr;
    int    beat_idx;
    cycle_no = 0;
    cur_addr = IDLE_ADDR;
    beat_idx = 0;
    forever begin
      @(negedge CLK);
      cycle_no++;
      if (init_rd_txn) begin
        burst_addrs.push_back(rd_addr);
        cur_addr = rd_addr;
        beat_idx = 0;
      end
      if (weight_buf_wr || act_buf_wr) begin
        check_word("buf_wr_data", buf_wr_data, beat_data(cur_addr, beat_idx));
        beat_idx++;
        if (weight_buf_wr) begin
          weight_strobes++;
        end
        if (act_buf_wr) begin
          act_strobes++;
        end
      end
      if (run_watch) begin
        if (out_wr) begin
          if (out_wr_cnt == 0) begin
            first_out_valid = valid_seen;
            first_out_cycle = cycle_no;
          end
          out_wr_cnt++;
          last_out_cycle = cycle_no;
        end else if (out_wr_cnt == 0) begin
          // while priming or computing stall follows missing activations
          check_word("stall", word_t'(stall), word_t'(!act_valid));
          if (act_valid) begin
            valid_seen++;
          end
        end
        if (pe_status[STAT_COMPUTED] && computed_cycle < 0) begin
          computed_cycle = cycle_no;
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: run did not end within %0d ns", WATCHDOG_NS);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] rng;
    int          n;
    rng = LCG_SEED;
    RESETN = 1'b0;
    acc_params = '0;
    mem_ctrl = '0;
    weight_base_addr = 32'h1000_0100;
    input_base_addr = 32'h2000_0a00;
    act_valid = 1'b0;
    clear_fetch_stats();
    repeat (8) @(posedge CLK);
    #1;
    RESETN = 1'b1;

    @(negedge CLK);
    check_word("pe_status", pe_status, '0);
    check_addr("rd_addr", rd_addr, IDLE_ADDR);
    check_word("stall", word_t'(stall), 32'd1);
    check_word("out_wr", word_t'(out_wr), '0);
    check_word("init_rd_txn", word_t'(init_rd_txn), '0);
    finish_test("reset values");
    @(posedge CLK);
    #1;

    clear_fetch_stats();
    mem_ctrl[MEMCTL_BUF_WEIGHTS] = 1'b1;
    wait_status(STAT_WEIGHTS_OK, T_WEIGHT, "weight request");
    mem_ctrl = '0;
    check_bursts(weight_base_addr, WEIGHT_BURSTS, "weight");
    check_word("weight_buf_wr count", word_t'(weight_strobes),
               word_t'(WEIGHT_BURSTS * BURST_LEN));
    check_word("act_buf_wr count", word_t'(act_strobes), '0);
    check_word("pe_status", pe_status, expected_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    finish_test("weight fetch");

    // fail the second input burst
    clear_fetch_stats();
    error_burst = bursts_served + 1;
    mem_ctrl[MEMCTL_BUF_INPUTS] = 1'b1;
    wait_status(STAT_INPUTS_OK, T_INPUT, "input request");
    mem_ctrl = '0;
    error_burst = -1;
    check_bursts(input_base_addr, INPUT_BURSTS, "input");
    check_word("act_buf_wr count", word_t'(act_strobes), word_t'(INPUT_BURSTS * BURST_LEN));
    check_word("weight_buf_wr count", word_t'(weight_strobes), '0);
    check_word("pe_status", pe_status, expected_status(1'b1, 1'b1, 1'b0, 1'b0, 1'b1));
    finish_test("input fetch with error");

    acc_params = make_params(4'd3, 4'd2, 4'd4, 1'b0, 1'b0, 1'b1);
    @(posedge CLK);
    #1;
    check_mux(4'd3, 4'd2, 4'd4);
    acc_params = make_params(4'd5, 4'd4, 4'd2, 1'b0, 1'b0, 1'b1);
    @(posedge CLK);
    #1;
    check_mux(4'd5, 4'd4, 4'd2);
    finish_test("mux controls");

    valid_seen = 0;
    out_wr_cnt = 0;
    first_out_valid = 0;
    first_out_cycle = 0;
    last_out_cycle = 0;
    computed_cycle = -1;
    acc_params = make_params(4'd3, 4'd2, 4'd4, 1'b0, 1'b1, 1'b1);
    @(posedge CLK);
    #1;
    run_watch = 1'b1;
    n = 0;
    while (pe_status[STAT_COMPUTED] !== 1'b1 && n < T_RUN) begin
      rng = lcg_step(rng);
      act_valid = (rng[22:21] != 2'b00);
      @(posedge CLK);
      #1;
      n++;
    end
    act_valid = 1'b0;
    if (pe_status[STAT_COMPUTED] !== 1'b1) begin
      report_problem("MAC run did not set the computed flag");
    end
    @(negedge CLK);
    #1;
    run_watch = 1'b0;
    check_count("out_wr cycles", run_count_t'(out_wr_cnt), expected_run_len(4'd4, 4'd3));
    check_count("act_valid cycles before out_wr", run_count_t'(first_out_valid),
                run_count_t'(MAC_PIPE_DEPTH) + expected_run_len(4'd4, 4'd3));
    check_count("out_wr span", run_count_t'(last_out_cycle - first_out_cycle + 1),
                run_count_t'(out_wr_cnt));
    check_count("computed status delay", run_count_t'(computed_cycle - last_out_cycle),
                run_count_t'(2));
    @(posedge CLK);
    #1;
    acc_params = make_params(4'd3, 4'd2, 4'd4, 1'b0, 1'b0, 1'b1);
    @(posedge CLK);
    #1;
    check_word("pe_status", pe_status, expected_status(1'b1, 1'b1, 1'b1, 1'b0, 1'b1));
    finish_test("MAC run");

    acc_params = make_params(4'd3, 4'd2, 4'd4, 1'b1, 1'b0, 1'b1);
    @(negedge CLK);
    check_word("mac_resetn", word_t'(mac_resetn), '0);
    @(posedge CLK);
    #1;
    @(posedge CLK);
    #1;
    // cleared controls read like R=1, S=0, tile=1
    check_mux(4'd1, 4'd0, 4'd1);
    check_word("pe_status", pe_status, expected_status(1'b1, 1'b1, 1'b0, 1'b0, 1'b1));
    acc_params = '0;
    @(negedge CLK);
    check_word("mac_resetn", word_t'(mac_resetn), 32'd1);
    finish_test("soft reset");

    $display("summary: %0d tests, %0d checks, %0d errors", test_no, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== pe_control_unit.f ====
source/pe_array_pkg.sv
source/pe_mem_pkg.sv
source/fetch_sequencer.sv
source/mac_sequencer.sv
source/pe_status_reg.sv
source/pe_control_unit.sv
verif/pe_control_unit_props.sv
verif/tb_pe_control_unit.sv

// ==== Makefile ====
SHELL := /bin/bash

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_pe_control_unit -f pe_control_unit.f
	set -o pipefail; ./obj_dir/Vtb_pe_control_unit | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
